// File: Makefile
# Verilator build for the VC loopback network interface

VERILATOR  ?= verilator
TOP        ?= tb_ni_vc_loopback
RTL_TOP    ?= ni_vc_loopback
FILELIST   ?= list.f
OBJ_DIR    ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall

RTL_SRCS := hw/ni_pkg.sv \
            hw/ni_rx_port.sv \
            hw/flit_fifo.sv \
            hw/ni_tx_port.sv \
            hw/ni_vc_loopback.sv
TB_SRCS  := bench/tb_ni_vc_loopback.sv
SIM_BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The simulator exits non-zero on $fatal, so make fails with it
run: build
	./$(SIM_BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: bench/ni_stimulus.txt
// Header words: flit count, stall start cycle, stall length in cycles
// Then one flit per line: type code (0 body, 1 head, 3 tail), 62-bit payload
14
0c
28
// Packet 1
1 0000000000010000
0 0000000000010001
0 0000000000010002
3 0000000000010003
// Packet 2
1 0000000000020000
0 0000000000020001
0 0000000000020002
0 0000000000020003
3 0000000000020004
// Packet 3
1 0000000000030000
0 0000000000030001
3 0000000000030002
// Packet 4
1 0000000000040000
0 0000000000040001
0 0000000000040002
0 0000000000040003
0 0000000000040004
3 0000000000040005
// Packet 5
1 0000000000050000
3 0000000000050001

// File: bench/tb_ni_vc_loopback.sv
// Testbench for the VC loopback network interface
// Injects the flits from the stimulus file, applies random and
// stalled back-pressure on the outbound side and checks plane
// rotation, VC gating, occupancy and flit order against models.

`timescale 1ns/10ps

module tb_ni_vc_loopback;

  import ni_pkg::*;

  localparam int          NumVcs        = 2;
  localparam int          FifoDepth     = 8;
  localparam int          VcWidth       = $clog2(NumVcs);
  localparam int          ClkHalf       = 5;
  localparam int          ResetCycles   = 5;
  localparam int          DrainCycles   = 4;
  localparam int          TimeoutFactor = 20;
  localparam int          HeaderWords   = 3;
  localparam int          MaxFlits      = 32;
  localparam logic [31:0] LfsrSeed      = 32'h327c_1959;
  localparam string       StimFile      = "bench/ni_stimulus.txt";

  logic               clk_i = 1'b0;
  logic               rst_ni;
  flit_t              rx_flit_i;
  logic               rx_valid_i;
  logic               rx_ready_o;
  flit_t              tx_flit_o;
  logic               tx_valid_o;
  logic               tx_ready_i;
  logic [VcWidth-1:0] vc_o;

  logic [63:0] stim_mem [HeaderWords + 2 * MaxFlits];

  int n_flits;
  int stall_start;
  int stall_len;
  int timeout_cycles;
  logic stim_loaded = 1'b0;

  // Models of the DUT state for the current cycle
  logic [VcWidth-1:0] vc_m;
  logic [VcWidth-1:0] in_vc_m;
  logic [VcWidth-1:0] out_vc_m;
  int                 occ_m;

  int          cycle;
  int          in_idx;
  int          out_count;
  int          head_wait;
  logic        rx_fire;
  logic        tx_fire;
  logic        saw_full;
  logic [31:0] lfsr_state;

  always #ClkHalf clk_i = ~clk_i;

  ni_vc_loopback #(
    .NumVcs     ( NumVcs     ),
    .FifoDepth  ( FifoDepth  )
  ) u_dut (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .rx_flit_i  ( rx_flit_i  ),
    .rx_valid_i ( rx_valid_i ),
    .rx_ready_o ( rx_ready_o ),
    .tx_flit_o  ( tx_flit_o  ),
    .tx_valid_o ( tx_valid_o ),
    .tx_ready_i ( tx_ready_i ),
    .vc_o       ( vc_o       )
  );

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string test_name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    stop_with_failure($sformatf("[FAIL] %s: expected %h, actual %h",
                                test_name, expected, actual));
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic take_random_bit(output logic b);
    lfsr_state = lfsr_step(lfsr_state);
    b = lfsr_state[0];
  endtask

  function automatic logic [VcWidth-1:0] next_vc(input logic [VcWidth-1:0] v);
    logic [VcWidth-1:0] n;
    if (v == VcWidth'(NumVcs - 1)) begin
      n = '0;
    end else begin
      n = v + 1'b1;
    end
    return n;
  endfunction

  function automatic flit_t flit_at(input int idx);
    flit_t f;
    int    base;
    base      = HeaderWords + 2 * idx;
    f.ftype   = flit_type_e'(stim_mem[base][FlitTypeWidth-1:0]);
    f.payload = stim_mem[base + 1][PayloadWidth-1:0];
    return f;
  endfunction

  function automatic logic in_stall(input int c);
    return (c >= stall_start) && (c < stall_start + stall_len);
  endfunction

  // ------------------------------
  // Stimulus, driven on the rising edge
  // ------------------------------
  task automatic drive_inputs();
    logic r0;
    logic r1;
    // A rejected head re-claims the plane, so wait until it comes round again
    if (rx_fire) begin
      in_idx++;
    end else if (rx_valid_i && rx_flit_i.ftype == HEAD) begin
      head_wait = NumVcs - 1;
    end
    if (in_idx < n_flits && head_wait == 0) begin
      rx_valid_i <= 1'b1;
      rx_flit_i  <= flit_at(in_idx);
    end else begin
      rx_valid_i <= 1'b0;
      if (head_wait > 0) begin
        head_wait--;
      end
    end
    if (in_stall(cycle)) begin
      tx_ready_i <= 1'b0;
    end else begin
      // Ready about three cycles out of four
      take_random_bit(r0);
      take_random_bit(r1);
      tx_ready_i <= r0 | r1;
    end
  endtask

  // ------------------------------
  // Checks, sampled on the falling edge
  // ------------------------------
  task automatic check_outputs();
    logic  exp_rx_ready;
    logic  exp_tx_valid;
    flit_t exp_flit;
    exp_rx_ready = (vc_m == in_vc_m) && (occ_m < FifoDepth);
    exp_tx_valid = (vc_m == out_vc_m) && (occ_m > 0);

    if (cycle == 0) begin
      assert (tx_valid_o === 1'b0)
        else report_mismatch("reset state tx_valid_o", 64'd0, 64'(tx_valid_o));
      assert (vc_o === '0)
        else report_mismatch("reset state vc_o", 64'd0, 64'(vc_o));
    end
    assert (vc_o === vc_m)
      else report_mismatch("plane rotation", 64'(vc_m), 64'(vc_o));
    assert (rx_ready_o === exp_rx_ready)
      else report_mismatch("inbound gating", 64'(exp_rx_ready), 64'(rx_ready_o));
    assert (tx_valid_o === exp_tx_valid)
      else report_mismatch("outbound gating", 64'(exp_tx_valid), 64'(tx_valid_o));

    if (in_stall(cycle) && occ_m >= FifoDepth) begin
      saw_full = 1'b1;
      assert (rx_ready_o === 1'b0)
        else report_mismatch("back-pressure", 64'd0, 64'(rx_ready_o));
    end

    rx_fire = rx_valid_i && exp_rx_ready;
    tx_fire = exp_tx_valid && tx_ready_i;

    if (tx_fire) begin
      exp_flit = flit_at(out_count);
      assert (64'(tx_flit_o) === 64'(exp_flit))
        else report_mismatch($sformatf("flit order, flit %0d", out_count),
                             64'(exp_flit), 64'(tx_flit_o));
      if (exp_flit.ftype == TAIL) begin
        out_vc_m = next_vc(out_vc_m);
      end
      out_count++;
    end

    // Any presented head claims the active plane
    if (rx_valid_i && rx_flit_i.ftype == HEAD) begin
      in_vc_m = vc_m;
    end
    if (rx_fire) begin
      occ_m++;
    end
    if (tx_fire) begin
      occ_m--;
    end
    vc_m = next_vc(vc_m);
  endtask

  task automatic run_cycle();
    @(negedge clk_i);
    check_outputs();
    @(posedge clk_i);
    cycle++;
    drive_inputs();
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin : main
    rst_ni     = 1'b0;
    rx_flit_i  = '0;
    rx_valid_i = 1'b0;
    tx_ready_i = 1'b0;
    vc_m       = '0;
    in_vc_m    = '0;
    out_vc_m   = '0;
    occ_m      = 0;
    cycle      = 0;
    in_idx     = 0;
    out_count  = 0;
    head_wait  = 0;
    rx_fire    = 1'b0;
    tx_fire    = 1'b0;
    saw_full   = 1'b0;
    lfsr_state = LfsrSeed;

    $readmemh(StimFile, stim_mem);
    n_flits     = int'(stim_mem[0][15:0]);
    stall_start = int'(stim_mem[1][15:0]);
    stall_len   = int'(stim_mem[2][15:0]);
    if (n_flits < 1 || n_flits > MaxFlits) begin
      stop_with_failure("stimulus file gives an unusable flit count");
    end
    timeout_cycles = ResetCycles + TimeoutFactor * (n_flits + stall_len);
    stim_loaded    = 1'b1;

    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;
    drive_inputs();

    while (out_count < n_flits) begin
      run_cycle();
    end
    // Nothing else may come out once the last flit has left
    repeat (DrainCycles) run_cycle();

    if (!saw_full || in_idx != n_flits || occ_m != 0) begin
      stop_with_failure("buffer never filled during the stall or flits were left over");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

  initial begin : watchdog
    wait (stim_loaded);
    repeat (timeout_cycles) @(posedge clk_i);
    stop_with_failure($sformatf("timeout: run still busy after %0d cycles", timeout_cycles));
  end

endmodule

// File: hw/flit_fifo.sv
// Flit buffer between the receive and transmit ports
// Circular buffer with valid/ready on both sides. A read and a write
// may happen in the same cycle. Written flits show up on the read
// side one cycle later at the earliest.

`timescale 1ns/10ps

module flit_fifo #(
  parameter int unsigned FifoDepth = 8
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  // Write side
  input  ni_pkg::flit_t wr_flit_i,
  input  logic          wr_valid_i,
  output logic          wr_ready_o,
  // Read side
  output ni_pkg::flit_t rd_flit_o,
  output logic          rd_valid_o,
  input  logic          rd_ready_i
);

  import ni_pkg::*;

  localparam int unsigned PtrWidth = $clog2(FifoDepth);
  localparam int unsigned CntWidth = $clog2(FifoDepth + 1);

  localparam logic [PtrWidth-1:0] LastPtr = PtrWidth'(FifoDepth - 1);
  localparam logic [CntWidth-1:0] FullCnt = CntWidth'(FifoDepth);

  flit_t mem_q [FifoDepth];

  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                wr_en;
  logic                rd_en;

  // ------------------------------
  // Handshake
  // ------------------------------
  assign wr_ready_o = (count_q != FullCnt);
  assign rd_valid_o = (count_q != '0);
  assign rd_flit_o  = mem_q[rd_ptr_q];

  assign wr_en = wr_valid_i & wr_ready_o;
  assign rd_en = rd_valid_o & rd_ready_i;

  // Storage
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= wr_flit_i;
    end
  end

  // ------------------------------
  // Pointers and occupancy
  // ------------------------------
  // Explicit wrap so depths that are not a power of two work too
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
    end else if (wr_en) begin
      wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
    end else if (rd_en) begin
      rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else begin
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  a_ptrs_meet_at_ends : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ((count_q == '0) || (count_q == FullCnt)) |-> (wr_ptr_q == rd_ptr_q)
  ) else $error("pointers apart while the buffer is empty or full");

  a_count_in_range : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    count_q <= FullCnt
  ) else $error("buffer occupancy above FifoDepth");

endmodule

// File: hw/ni_pkg.sv
// Network interface flit definitions
// Shared by the receive port, the flit buffer and the transmit port.
// A flit carries a 2-bit type code at the top and payload below it.

package ni_pkg;

  // ------------------------------
  // Flit geometry
  // ------------------------------
  localparam int unsigned FlitWidth     = 64;
  localparam int unsigned FlitTypeWidth = 2;

  // Payload gets everything below the type field
  localparam int unsigned PayloadWidth  = FlitWidth - FlitTypeWidth;

  // ------------------------------
  // Flit type codes
  // ------------------------------
  typedef enum logic [FlitTypeWidth-1:0] {
    BODY   = 2'b00,
    HEAD   = 2'b01,
    UNUSED = 2'b10,
    TAIL   = 2'b11
  } flit_type_e;

  // Type sits in bits 63:62, payload in 61:0
  typedef struct packed {
    flit_type_e               ftype;
    logic [PayloadWidth-1:0]  payload;
  } flit_t;

endpackage

// File: hw/ni_rx_port.sv
// Inbound side of the network interface
// Rotates the active VC plane every clock and allocates the inbound
// VC when a head flit shows up. Flits go to the buffer only while the
// allocated plane is active, and ready back to the router is gated
// the same way.

`timescale 1ns/10ps

module ni_rx_port #(
  parameter  int unsigned NumVcs  = 2,
  localparam int unsigned VcWidth = $clog2(NumVcs)
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Router side
  input  ni_pkg::flit_t        rx_flit_i,
  input  logic                 rx_valid_i,
  output logic                 rx_ready_o,
  // Buffer write side
  output ni_pkg::flit_t        wr_flit_o,
  output logic                 wr_valid_o,
  input  logic                 wr_ready_i,
  // Active plane
  output logic [VcWidth-1:0]   cur_vc_o
);

  import ni_pkg::*;

  localparam logic [VcWidth-1:0] LastVc = VcWidth'(NumVcs - 1);

  logic [VcWidth-1:0] cur_vc_q;
  logic [VcWidth-1:0] in_vc_q;
  logic               vc_active;
  logic               head_seen;

  // ------------------------------
  // VC plane rotation
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cur_vc_q <= '0;
    end else if (cur_vc_q == LastVc) begin
      cur_vc_q <= '0;
    end else begin
      cur_vc_q <= cur_vc_q + 1'b1;
    end
  end

  assign cur_vc_o = cur_vc_q;

  // ------------------------------
  // Inbound VC allocation
  // ------------------------------
  // Any valid head claims whatever plane is active right now
  assign head_seen = rx_valid_i && (rx_flit_i.ftype == HEAD);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_vc_q <= '0;
    end else if (head_seen) begin
      in_vc_q <= cur_vc_q;
    end
  end

  // ------------------------------
  // Plane-gated handshake
  // ------------------------------
  assign vc_active  = (in_vc_q == cur_vc_q);

  assign wr_flit_o  = rx_flit_i;
  assign wr_valid_o = rx_valid_i & vc_active;
  assign rx_ready_o = wr_ready_i & vc_active;

  // Claimed plane has already rotated away one cycle after a head
  a_gap_after_head : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    head_seen |=> !rx_ready_o
  ) else $error("rx_ready_o high right after a head claimed the plane");

endmodule

// File: hw/ni_tx_port.sv
// Outbound side of the network interface
// Starts on plane 0 and moves each new packet to the next plane once
// the tail flit of the previous one is accepted. The flit is offered,
// and ready passed back to the buffer, only while that plane is active.

`timescale 1ns/10ps

module ni_tx_port #(
  parameter  int unsigned NumVcs  = 2,
  localparam int unsigned VcWidth = $clog2(NumVcs)
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Buffer read side
  input  ni_pkg::flit_t       rd_flit_i,
  input  logic                rd_valid_i,
  output logic                rd_ready_o,
  // Active plane from the receive port
  input  logic [VcWidth-1:0]  cur_vc_i,
  // Router side
  output ni_pkg::flit_t       tx_flit_o,
  output logic                tx_valid_o,
  input  logic                tx_ready_i
);

  import ni_pkg::*;

  localparam logic [VcWidth-1:0] LastVc = VcWidth'(NumVcs - 1);

  logic [VcWidth-1:0] out_vc_q;
  logic               vc_active;
  logic               tail_done;

  // ------------------------------
  // Outbound VC per packet
  // ------------------------------
  assign tail_done = (rd_flit_i.ftype == TAIL) & tx_valid_o & tx_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_vc_q <= '0;
    end else if (tail_done) begin
      out_vc_q <= (out_vc_q == LastVc) ? '0 : out_vc_q + 1'b1;
    end
  end

  // ------------------------------
  // Plane-gated handshake
  // ------------------------------
  assign vc_active  = (out_vc_q == cur_vc_i);

  // Head of the buffer is always visible
  assign tx_flit_o  = rd_flit_i;
  assign tx_valid_o = rd_valid_i & vc_active;
  assign rd_ready_o = tx_ready_i & vc_active;

  // An offered flit that is not taken stays on the output
  a_hold_until_taken : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (tx_valid_o && !tx_ready_i) |=> $stable(tx_flit_o)
  ) else $error("tx_flit_o changed before the offered flit was taken");

endmodule

// File: hw/ni_vc_loopback.sv
// VC loopback network interface
// Flits from the router enter through the receive port, wait in the
// flit buffer and go back to the router through the transmit port.
// vc_o tells the router which VC plane is active.

`timescale 1ns/10ps

module ni_vc_loopback #(
  parameter int unsigned NumVcs    = 2,
  parameter int unsigned FifoDepth = 8
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Inbound from the router
  input  ni_pkg::flit_t               rx_flit_i,
  input  logic                        rx_valid_i,
  output logic                        rx_ready_o,
  // Outbound to the router
  output ni_pkg::flit_t               tx_flit_o,
  output logic                        tx_valid_o,
  input  logic                        tx_ready_i,
  // Active plane
  output logic [$clog2(NumVcs)-1:0]   vc_o
);

  import ni_pkg::*;

  // ------------------------------
  // Internal links
  // ------------------------------
  flit_t                      wr_flit;
  logic                       wr_valid;
  logic                       wr_ready;
  flit_t                      rd_flit;
  logic                       rd_valid;
  logic                       rd_ready;
  logic [$clog2(NumVcs)-1:0]  cur_vc;

  assign vc_o = cur_vc;

  ni_rx_port #(
    .NumVcs     ( NumVcs     )
  ) u_rx (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .rx_flit_i  ( rx_flit_i  ),
    .rx_valid_i ( rx_valid_i ),
    .rx_ready_o ( rx_ready_o ),
    .wr_flit_o  ( wr_flit    ),
    .wr_valid_o ( wr_valid   ),
    .wr_ready_i ( wr_ready   ),
    .cur_vc_o   ( cur_vc     )
  );

  flit_fifo #(
    .FifoDepth  ( FifoDepth  )
  ) u_fifo (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .wr_flit_i  ( wr_flit    ),
    .wr_valid_i ( wr_valid   ),
    .wr_ready_o ( wr_ready   ),
    .rd_flit_o  ( rd_flit    ),
    .rd_valid_o ( rd_valid   ),
    .rd_ready_i ( rd_ready   )
  );

  ni_tx_port #(
    .NumVcs     ( NumVcs     )
  ) u_tx (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .rd_flit_i  ( rd_flit    ),
    .rd_valid_i ( rd_valid   ),
    .rd_ready_o ( rd_ready   ),
    .cur_vc_i   ( cur_vc     ),
    .tx_flit_o  ( tx_flit_o  ),
    .tx_valid_o ( tx_valid_o ),
    .tx_ready_i ( tx_ready_i )
  );

endmodule

// File: list.f
hw/ni_pkg.sv
hw/ni_rx_port.sv
hw/flit_fifo.sv
hw/ni_tx_port.sv
hw/ni_vc_loopback.sv
bench/tb_ni_vc_loopback.sv
